// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

        typedef logic [4:0]  regAddr;
        typedef logic [31:0] dataWord;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Instruction word, read as either format.
        typedef union packed {
                struct packed {
                        logic [5:0] opcode;
                        regAddr     rs;
                        regAddr     rt;
                        regAddr     rd;
                        logic [4:0] shamt;
                        logic [5:0] funct;
                } rType;
                struct packed {
                        logic [5:0]  opcode;
                        regAddr      rs;
                        regAddr      rt;
                        logic [15:0] imm16;
                } iType;
        } instrWord;

        localparam logic [5:0] OP_RTYPE = 6'h00;
        localparam logic [5:0] OP_ADDIU = 6'h09;
        localparam logic [5:0] OP_ANDI  = 6'h0c;
        localparam logic [5:0] OP_ORI   = 6'h0d;
        localparam logic [5:0] OP_LUI   = 6'h0f;
        localparam logic [5:0] OP_LW    = 6'h23;
        localparam logic [5:0] OP_SW    = 6'h2b;

        localparam logic [5:0] FN_SLL  = 6'h00;
        localparam logic [5:0] FN_ADDU = 6'h21;
        localparam logic [5:0] FN_SUBU = 6'h23;
        localparam logic [5:0] FN_AND  = 6'h24;
        localparam logic [5:0] FN_OR   = 6'h25;
        localparam logic [5:0] FN_SLT  = 6'h2a;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
        } aluOpE;

        typedef enum logic [1:0] {SRC_ALU = 2'd0, SRC_MEMORY = 2'd1} regSrcE;

        // Zero is none, so a cleared control word writes nothing.
        typedef enum logic [1:0] {DST_NONE = 2'd0, DST_RD = 2'd1, DST_RT = 2'd2} regDstE;

        typedef struct packed {
                logic   regWe;
                logic   memWe;
                logic   extOp;    // Sign extension of imm16.
                aluOpE  aluOp;
                logic   aluSrc1;  // Shamt in place of rs.
                logic   aluSrc2;  // Immediate in place of rt.
                regSrcE regSrc;
                regDstE regDst;
        } ctrlFields;

        typedef struct packed {
                regAddr      rs;
                regAddr      rt;
                regAddr      rd;
                logic [15:0] imm16;
                logic [4:0]  shamt;
                ctrlFields   ctrl;
                dataWord     readData1;
                dataWord     readData2;
        } decodedInstr;

        typedef struct packed {
                ctrlFields ctrl;
                regAddr    dest;
                dataWord   aluResult;
                dataWord   storeData;
        } exResult;

        typedef struct packed {
                regAddr  regNum;
                dataWord data;
        } retireRec;

endpackage

`default_nettype wire

// ==== hdl/instrBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrBuffer #(
        parameter int INSTR_BUF_DEPTH = 2
) (
        input  logic             clk,
        input  logic             rstN,
        input  logic             instrValid,
        input  cpuPkg::instrWord instr,
        input  logic             pop,
        output logic             headValid,
        output cpuPkg::instrWord head,
        output logic             creditReturn
);
        import cpuPkg::*;

        localparam int PTR_W = (INSTR_BUF_DEPTH > 1) ? $clog2(INSTR_BUF_DEPTH) : 1;
        localparam int CNT_W = $clog2(INSTR_BUF_DEPTH + 1);

        instrWord           entries [INSTR_BUF_DEPTH];
        logic [PTR_W-1:0]   wrPtr;
        logic [PTR_W-1:0]   rdPtr;
        logic [CNT_W-1:0]   count;
        logic               doPop;

        function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
                nextPtr = (ptr == PTR_W'(INSTR_BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        assign headValid    = (count != '0);
        assign head         = entries[rdPtr];
        assign doPop        = pop & headValid;
        assign creditReturn = doPop;   // One credit per entry leaving.

        // No full check, the source never sends without a credit.
        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        wrPtr   <= '0;
                        rdPtr   <= '0;
                        count   <= '0;
                        entries <= '{default: '0};
                end
                else
                begin
                        if (instrValid)
                        begin
                                entries[wrPtr] <= instr;
                                wrPtr          <= nextPtr(wrPtr);
                        end
                        if (doPop)
                                rdPtr <= nextPtr(rdPtr);
                        count <= count + CNT_W'(instrValid) - CNT_W'(doPop);
                end
        end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
        input  logic                headValid,
        input  cpuPkg::instrWord    head,
        output logic                pop,
        output cpuPkg::regAddr      rsAddr,
        output cpuPkg::regAddr      rtAddr,
        input  cpuPkg::dataWord     readData1,
        input  cpuPkg::dataWord     readData2,
        output cpuPkg::decodedInstr decoded,
        output logic                flushE
);
        import cpuPkg::*;

        ctrlFields ctrl;

        assign pop    = headValid;
        assign flushE = ~headValid;   // Empty buffer sends a bubble.

        assign rsAddr = head.rType.rs;
        assign rtAddr = head.rType.rt;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Control decode.
        always_comb
        begin
                ctrl = '0;
                case (head.iType.opcode)
                        OP_RTYPE:
                        begin
                                ctrl.regWe  = 1'b1;
                                ctrl.regDst = DST_RD;
                                case (head.rType.funct)
                                        FN_ADDU: ctrl.aluOp = ALU_ADD;
                                        FN_SUBU: ctrl.aluOp = ALU_SUB;
                                        FN_AND:  ctrl.aluOp = ALU_AND;
                                        FN_OR:   ctrl.aluOp = ALU_OR;
                                        FN_SLT:  ctrl.aluOp = ALU_SLT;
                                        FN_SLL:
                                        begin
                                                ctrl.aluOp   = ALU_SLL;
                                                ctrl.aluSrc1 = 1'b1;
                                        end
                                        default: ctrl = '0;   // Unknown funct.
                                endcase
                        end
                        OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW:
                        begin
                                ctrl.regWe   = 1'b1;
                                ctrl.aluSrc2 = 1'b1;
                                ctrl.regDst  = DST_RT;
                                case (head.iType.opcode)
                                        OP_ANDI: ctrl.aluOp = ALU_AND;
                                        OP_ORI:  ctrl.aluOp = ALU_OR;
                                        OP_LUI:  ctrl.aluOp = ALU_LUI;
                                        default:
                                        begin
                                                ctrl.aluOp = ALU_ADD;
                                                ctrl.extOp = 1'b1;
                                        end
                                endcase
                                if (head.iType.opcode == OP_LW)
                                        ctrl.regSrc = SRC_MEMORY;
                        end
                        OP_SW:
                        begin
                                ctrl.memWe   = 1'b1;
                                ctrl.extOp   = 1'b1;
                                ctrl.aluOp   = ALU_ADD;
                                ctrl.aluSrc2 = 1'b1;
                        end
                        default: ctrl = '0;
                endcase
        end

        always_comb
        begin
                decoded.rs        = head.rType.rs;
                decoded.rt        = head.rType.rt;
                decoded.rd        = head.rType.rd;
                decoded.shamt     = head.rType.shamt;
                decoded.imm16     = head.iType.imm16;
                decoded.ctrl      = ctrl;
                decoded.readData1 = readData1;
                decoded.readData2 = readData2;
        end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
        input  logic            clk,
        input  logic            rstN,
        input  cpuPkg::regAddr  rsAddr,
        input  cpuPkg::regAddr  rtAddr,
        output cpuPkg::dataWord readData1,
        output cpuPkg::dataWord readData2,
        input  logic            we,
        input  cpuPkg::regAddr  wAddr,
        input  cpuPkg::dataWord wData
);
        import cpuPkg::*;

        dataWord regs [1:31];   // Register zero is not stored.

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                        regs <= '{default: '0};
                else if (we && wAddr != '0)
                        regs[wAddr] <= wData;
        end

        // Reads pass a same-cycle write straight through.
        assign readData1 = (rsAddr == '0) ? '0 : (we && rsAddr == wAddr) ? wData : regs[rsAddr];
        assign readData2 = (rtAddr == '0) ? '0 : (we && rtAddr == wAddr) ? wData : regs[rtAddr];

endmodule

`default_nettype wire

// ==== hdl/idExReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module idExReg (
        input  logic                clk,
        input  logic                rstN,
        input  logic                flushE,
        input  cpuPkg::decodedInstr decodedD,
        output cpuPkg::decodedInstr decodedE,
        output logic                validE
);

        // A cleared word has every control inactive.
        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                begin
                        decodedE <= '0;
                        validE   <= 1'b0;
                end
                else if (flushE)
                begin
                        decodedE <= '0;
                        validE   <= 1'b0;
                end
                else
                begin
                        decodedE <= decodedD;
                        validE   <= 1'b1;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
        input  cpuPkg::decodedInstr decodedE,
        input  logic                validE,
        input  logic                wbWe,
        input  cpuPkg::regAddr      wbReg,
        input  cpuPkg::dataWord     wbData,
        output cpuPkg::exResult     exOut
);
        import cpuPkg::*;

        dataWord rsVal;
        dataWord rtVal;
        dataWord extImm;
        dataWord srcA;
        dataWord srcB;
        dataWord aluResult;
        regAddr  dest;
        logic    fwdRs;
        logic    fwdRt;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Forwarding from write-back.
        assign fwdRs = wbWe && wbReg != '0 && wbReg == decodedE.rs;
        assign fwdRt = wbWe && wbReg != '0 && wbReg == decodedE.rt;
        assign rsVal = fwdRs ? wbData : decodedE.readData1;
        assign rtVal = fwdRt ? wbData : decodedE.readData2;

        assign extImm = decodedE.ctrl.extOp ? {{16{decodedE.imm16[15]}}, decodedE.imm16}
                                            : {16'h0000, decodedE.imm16};

        assign srcA = decodedE.ctrl.aluSrc1 ? {27'd0, decodedE.shamt} : rsVal;
        assign srcB = decodedE.ctrl.aluSrc2 ? extImm : rtVal;

        always_comb
        begin
                case (decodedE.ctrl.aluOp)
                        ALU_ADD: aluResult = srcA + srcB;
                        ALU_SUB: aluResult = srcA - srcB;
                        ALU_AND: aluResult = srcA & srcB;
                        ALU_OR:  aluResult = srcA | srcB;
                        ALU_SLT: aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
                        ALU_SLL: aluResult = srcB << srcA[4:0];
                        ALU_LUI: aluResult = {srcB[15:0], 16'h0000};
                        default: aluResult = '0;
                endcase
        end

        always_comb
        begin
                case (decodedE.ctrl.regDst)
                        DST_RD:  dest = decodedE.rd;
                        DST_RT:  dest = decodedE.rt;
                        default: dest = '0;
                endcase
        end

        // Writes to register zero are dropped here, so they never retire.
        always_comb
        begin
                exOut.ctrl       = decodedE.ctrl;
                exOut.ctrl.regWe = decodedE.ctrl.regWe && validE && dest != '0;
                exOut.ctrl.memWe = decodedE.ctrl.memWe && validE;
                exOut.dest       = dest;
                exOut.aluResult  = aluResult;
                exOut.storeData  = rtVal;
        end

endmodule

`default_nettype wire

// ==== hdl/memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWbStage #(
        parameter int DMEM_WORDS = 64
) (
        input  logic             clk,
        input  logic             rstN,
        input  cpuPkg::exResult  exIn,
        output logic             wbWe,
        output cpuPkg::regAddr   wbReg,
        output cpuPkg::dataWord  wbData,
        output logic             retireValid,
        output cpuPkg::retireRec retire
);
        import cpuPkg::*;

        localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

        exResult        exReg;
        dataWord        dmem [DMEM_WORDS];
        dataWord        wrWord;
        dataWord        rdWord;
        logic [AW-1:0]  wrIdx;
        logic [AW-1:0]  rdIdx;

        // Word address, wrapped onto the memory size.
        assign wrWord = (exIn.aluResult >> 2) % dataWord'(DMEM_WORDS);
        assign rdWord = (exReg.aluResult >> 2) % dataWord'(DMEM_WORDS);
        assign wrIdx  = wrWord[AW-1:0];
        assign rdIdx  = rdWord[AW-1:0];

        always_ff @(posedge clk or negedge rstN)
        begin
                if (!rstN)
                        exReg <= '0;
                else
                        exReg <= exIn;
        end

        always_ff @(posedge clk)
        begin
                if (exIn.ctrl.memWe)
                        dmem[wrIdx] <= exIn.storeData;   // Same edge as exReg.
        end

        assign wbWe   = exReg.ctrl.regWe;
        assign wbReg  = exReg.dest;
        assign wbData = (exReg.ctrl.regSrc == SRC_MEMORY) ? dmem[rdIdx] : exReg.aluResult;

        assign retireValid   = wbWe;
        assign retire.regNum = wbReg;
        assign retire.data   = wbData;

endmodule

`default_nettype wire

// ==== hdl/pipeCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeCore #(
        parameter int INSTR_BUF_DEPTH = 2,
        parameter int DMEM_WORDS      = 64
) (
        input  logic             clk,
        input  logic             rstN,
        input  logic             instrValid,
        input  cpuPkg::instrWord instr,
        output logic             creditReturn,
        output logic             retireValid,
        output cpuPkg::retireRec retire
);
        import cpuPkg::*;

        logic        headValid;
        instrWord    head;
        logic        pop;
        regAddr      rsAddr;
        regAddr      rtAddr;
        dataWord     readData1;
        dataWord     readData2;
        decodedInstr decodedD;
        decodedInstr decodedE;
        logic        flushE;
        logic        validE;
        exResult     exOut;
        logic        wbWe;
        regAddr      wbReg;
        dataWord     wbData;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Decode.
        instrBuffer #(.INSTR_BUF_DEPTH(INSTR_BUF_DEPTH)) u_instrBuffer (
                .clk          (clk),
                .rstN         (rstN),
                .instrValid   (instrValid),
                .instr        (instr),
                .pop          (pop),
                .headValid    (headValid),
                .head         (head),
                .creditReturn (creditReturn)
        );

        decodeStage u_decodeStage (
                .headValid (headValid),
                .head      (head),
                .pop       (pop),
                .rsAddr    (rsAddr),
                .rtAddr    (rtAddr),
                .readData1 (readData1),
                .readData2 (readData2),
                .decoded   (decodedD),
                .flushE    (flushE)
        );

        regFile u_regFile (
                .clk       (clk),
                .rstN      (rstN),
                .rsAddr    (rsAddr),
                .rtAddr    (rtAddr),
                .readData1 (readData1),
                .readData2 (readData2),
                .we        (wbWe),
                .wAddr     (wbReg),
                .wData     (wbData)
        );

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Execute and write-back.
        idExReg u_idExReg (
                .clk      (clk),
                .rstN     (rstN),
                .flushE   (flushE),
                .decodedD (decodedD),
                .decodedE (decodedE),
                .validE   (validE)
        );

        executeStage u_executeStage (
                .decodedE (decodedE),
                .validE   (validE),
                .wbWe     (wbWe),
                .wbReg    (wbReg),
                .wbData   (wbData),
                .exOut    (exOut)
        );

        memWbStage #(.DMEM_WORDS(DMEM_WORDS)) u_memWbStage (
                .clk         (clk),
                .rstN        (rstN),
                .exIn        (exOut),
                .wbWe        (wbWe),
                .wbReg       (wbReg),
                .wbData      (wbData),
                .retireValid (retireValid),
                .retire      (retire)
        );

endmodule

`default_nettype wire

// ==== verif/coreChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreChecker #(
        parameter int INSTR_BUF_DEPTH = 2,
        parameter int DMEM_WORDS      = 64
) (
        input logic             clk,
        input logic             rstN,
        input logic             instrValid,
        input cpuPkg::instrWord instr,
        input logic             creditReturn,
        input logic             retireValid,
        input cpuPkg::retireRec retire
);
        import cpuPkg::*;

        dataWord  modelRegs [32];
        dataWord  modelMem  [DMEM_WORDS];
        retireRec expQ [$];
        retireRec modelRec;
        retireRec expRec;
        int       credits    = INSTR_BUF_DEPTH;
        logic     sentAny    = 1'b0;
        int       mismatches = 0;
        int       unexpected = 0;
        int       protocol   = 0;

        function automatic int memIndex(input dataWord addr);
                return int'((addr >> 2) % DMEM_WORDS);   // Word address, wrapped.
        endfunction

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Architectural model, one instruction at a time in program order.
        function automatic logic modelExecute(input instrWord iw, output retireRec rec);
                dataWord rsVal;
                dataWord rtVal;
                dataWord sext;
                dataWord zext;
                dataWord result;
                regAddr  dest;
                rsVal  = modelRegs[iw.iType.rs];
                rtVal  = modelRegs[iw.iType.rt];
                sext   = {{16{iw.iType.imm16[15]}}, iw.iType.imm16};
                zext   = {16'h0000, iw.iType.imm16};
                dest   = iw.iType.rt;
                result = '0;
                case (iw.iType.opcode)
                        OP_RTYPE:
                        begin
                                dest = iw.rType.rd;
                                case (iw.rType.funct)
                                        FN_ADDU: result = rsVal + rtVal;
                                        FN_SUBU: result = rsVal - rtVal;
                                        FN_AND:  result = rsVal & rtVal;
                                        FN_OR:   result = rsVal | rtVal;
                                        FN_SLT:  result = 32'($signed(rsVal) < $signed(rtVal));
                                        FN_SLL:  result = rtVal << iw.rType.shamt;
                                        default: dest = '0;
                                endcase
                        end
                        OP_ADDIU: result = rsVal + sext;
                        OP_ANDI:  result = rsVal & zext;
                        OP_ORI:   result = rsVal | zext;
                        OP_LUI:   result = {iw.iType.imm16, 16'h0000};
                        OP_LW:    result = modelMem[memIndex(rsVal + sext)];
                        OP_SW:
                        begin
                                modelMem[memIndex(rsVal + sext)] = rtVal;
                                dest = '0;   // Stores never retire.
                        end
                        default:  dest = '0;
                endcase
                if (dest != '0)
                        modelRegs[dest] = result;
                rec.regNum = dest;
                rec.data   = result;
                return dest != '0;
        endfunction

        always @(posedge clk)
        begin
                // Quiet outputs until the first instruction goes in.
                if (!sentAny && retireValid !== 1'b0)
                begin
                        protocol++;
                        $display("FAILED at %0t: retireValid expected 0, got %b",
                                 $time, retireValid);
                end
                if (!sentAny && creditReturn !== 1'b0)
                begin
                        protocol++;
                        $display("FAILED at %0t: creditReturn expected 0, got %b",
                                 $time, creditReturn);
                end
                if (!rstN)
                begin
                        modelRegs = '{default: '0};
                        expQ.delete();
                        credits = INSTR_BUF_DEPTH;
                        sentAny = 1'b0;
                end
                else
                begin
                        if (instrValid && credits == 0)
                        begin
                                protocol++;
                                $display("Instruction sent at %0t without a credit.", $time);
                        end
                        credits = credits + int'(creditReturn) - int'(instrValid);
                        if (credits > INSTR_BUF_DEPTH)
                        begin
                                protocol++;
                                $display("Credit count rose to %0d at %0t, above the depth %0d.",
                                         credits, $time, INSTR_BUF_DEPTH);
                        end
                        if (instrValid)
                        begin
                                sentAny = 1'b1;
                                if (modelExecute(instr, modelRec))
                                        expQ.push_back(modelRec);
                        end
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always @(posedge clk)
        begin
                if (rstN && retireValid)
                begin
                        if (expQ.size() == 0)
                        begin
                                unexpected++;
                                $display("Retire of r%0d = %h at %0t with no record expected.",
                                         retire.regNum, retire.data, $time);
                        end
                        else
                        begin
                                expRec = expQ.pop_front();
                                if (retire.regNum !== expRec.regNum)
                                begin
                                        mismatches++;
                                        $display("FAILED at %0t: retire.regNum expected %0d, %s",
                                                 $time, expRec.regNum,
                                                 $sformatf("got %0d", retire.regNum));
                                end
                                if (retire.data !== expRec.data)
                                begin
                                        mismatches++;
                                        $display("FAILED at %0t: retire.data expected %h, got %h",
                                                 $time, expRec.data, retire.data);
                                end
                        end
                end
        end

        function automatic int pending();
                return expQ.size();
        endfunction

        task automatic report(output int mism, output int miss, output int unexp, output int proto);
                retireRec rec;
                miss = expQ.size();
                while (expQ.size() != 0)
                begin
                        rec = expQ.pop_front();
                        $display("Missing retire of r%0d = %h.", rec.regNum, rec.data);
                end
                mism  = mismatches;
                unexp = unexpected;
                proto = protocol;
        endtask

endmodule

`default_nettype wire

// ==== verif/tbPipeCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbPipeCore;
        import cpuPkg::*;

        localparam int INSTR_BUF_DEPTH = 2;
        localparam int DMEM_WORDS      = 64;
        localparam int RESET_CYCLES    = 3;
        localparam int NUM_RANDOM      = 400;
        localparam int NUM_INSTR       = 2 * DMEM_WORDS + NUM_RANDOM;
        localparam int CYCLE_LIMIT     = 4 * NUM_INSTR + 50;

        logic     clk;
        logic     rstN;
        logic     instrValid;
        instrWord instr;
        logic     creditReturn;
        logic     retireValid;
        retireRec retire;
        int       seed;
        int       credits;
        int       cycles;

        pipeCore #(.INSTR_BUF_DEPTH(INSTR_BUF_DEPTH), .DMEM_WORDS(DMEM_WORDS)) u_dut (
                .clk          (clk),
                .rstN         (rstN),
                .instrValid   (instrValid),
                .instr        (instr),
                .creditReturn (creditReturn),
                .retireValid  (retireValid),
                .retire       (retire)
        );

        coreChecker #(.INSTR_BUF_DEPTH(INSTR_BUF_DEPTH), .DMEM_WORDS(DMEM_WORDS)) u_chk (
                .clk          (clk),
                .rstN         (rstN),
                .instrValid   (instrValid),
                .instr        (instr),
                .creditReturn (creditReturn),
                .retireValid  (retireValid),
                .retire       (retire)
        );

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Source side. Credits follow what crossed the last edge.
        task automatic nextEdge();
                @(posedge clk);
                credits = credits + int'(creditReturn) - int'(instrValid);
        endtask

        task automatic sendInstr(input instrWord iw);
                while (credits == 0)
                begin
                        instrValid <= 1'b0;
                        nextEdge();
                end
                instrValid <= 1'b1;
                instr      <= iw;
                nextEdge();
                instrValid <= 1'b0;
        endtask

        task automatic idleCycles(input int n);
                repeat (n)
                begin
                        instrValid <= 1'b0;
                        instr      <= instrWord'($random(seed));   // Junk, not accepted.
                        nextEdge();
                end
        endtask

        function automatic instrWord makeImm(input logic [5:0] op, input regAddr rt,
                                             input regAddr rs, input logic [15:0] imm);
                instrWord iw;
                iw.iType.opcode = op;
                iw.iType.rs     = rs;
                iw.iType.rt     = rt;
                iw.iType.imm16  = imm;
                return iw;
        endfunction

        // Few registers, so dependences come close together.
        function automatic regAddr pickReg();
                return regAddr'($unsigned($random(seed)) % 8);
        endfunction

        function automatic instrWord randomInstr();
                instrWord iw;
                int       kind;
                iw              = instrWord'($random(seed));
                iw.rType.rs     = pickReg();
                iw.rType.rt     = pickReg();
                iw.rType.rd     = pickReg();
                iw.rType.opcode = OP_RTYPE;
                kind            = $unsigned($random(seed)) % 12;
                case (kind)
                        0:       iw.rType.funct  = FN_ADDU;
                        1:       iw.rType.funct  = FN_SUBU;
                        2:       iw.rType.funct  = FN_AND;
                        3:       iw.rType.funct  = FN_OR;
                        4:       iw.rType.funct  = FN_SLT;
                        5:       iw.rType.funct  = FN_SLL;
                        6:       iw.iType.opcode = OP_ADDIU;
                        7:       iw.iType.opcode = OP_ANDI;
                        8:       iw.iType.opcode = OP_ORI;
                        9:       iw.iType.opcode = OP_LUI;
                        10:      iw.iType.opcode = OP_LW;
                        default: iw.iType.opcode = OP_SW;
                endcase
                // Full immediate for I-type words, so its top bit gets exercised.
                if (kind >= 6)
                        iw.iType.imm16 = 16'($random(seed));
                // Half the memory accesses hit words 0 and 1 through aliases.
                if (kind >= 10 && $unsigned($random(seed)) % 2 == 0)
                begin
                        iw.iType.rs = '0;
                        case ($unsigned($random(seed)) % 4)
                                0:       iw.iType.imm16 = 16'h0000;
                                1:       iw.iType.imm16 = 16'h0004;
                                2:       iw.iType.imm16 = 16'(4 * DMEM_WORDS);
                                default: iw.iType.imm16 = 16'(4 - 4 * DMEM_WORDS);
                        endcase
                end
                return iw;
        endfunction

        task automatic finishRun(input logic timedOut);
                int mism;
                int miss;
                int unexp;
                int proto;
                u_chk.report(mism, miss, unexp, proto);
                $display("Errors: %0d mismatched, %0d missing, %0d unexpected, %0d protocol.",
                         mism, miss, unexp, proto);
                if (!timedOut && mism + miss + unexp + proto == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        initial
        begin
                seed       = 47747;
                rstN       = 1'b0;
                instrValid = 1'b0;
                instr      = '0;
                credits    = INSTR_BUF_DEPTH;
                repeat (RESET_CYCLES) @(posedge clk);
                rstN <= 1'b1;
                nextEdge();
                // Every data word gets a pattern from its own address.
                for (int i = 0; i < DMEM_WORDS; i++)
                begin
                        sendInstr(makeImm(OP_ORI, 5'd1, 5'd0, {8'(i), ~8'(i)}));
                        sendInstr(makeImm(OP_SW, 5'd1, 5'd0, 16'(4 * i)));
                end
                for (int n = 0; n < NUM_RANDOM; n++)
                begin
                        if ($unsigned($random(seed)) % 4 == 0)
                                idleCycles(1 + $unsigned($random(seed)) % 3);
                        sendInstr(randomInstr());
                end
                while (u_chk.pending() != 0)
                        nextEdge();
                repeat (8) nextEdge();   // Room for stray retires.
                finishRun(1'b0);
        end

        initial
        begin
                cycles = 0;
                wait (rstN === 1'b1);
                while (cycles < CYCLE_LIMIT)
                begin
                        @(posedge clk);
                        cycles = cycles + 1;
                end
                $display("Timeout: the run was still busy after %0d cycles.", cycles);
                finishRun(1'b1);
        end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/cpuPkg.sv
hdl/instrBuffer.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/idExReg.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/pipeCore.sv
verif/coreChecker.sv
verif/tbPipeCore.sv
